// File: common/dab_cfg.svh
// Word width and register address map shared by the DAB modulator blocks
`ifndef DAB_CFG_SVH
`define DAB_CFG_SVH

// Width of every count, address and register word
`define DATA_WIDTH 16

// Generator control word, common to both chains
`define CTRL_ADDR 16'h0000

// Chain n owns the register window starting at (n + 1) * CHAIN_STRIDE
`define CHAIN_STRIDE 'h100

// Register offsets inside a chain window
`define COMPARE_OFFSET 'h00
`define COMPARE_STEP 'h04
`define PERIOD_OFFSET 'h1C
`define PHASE_OFFSET 'h20

// Compare registers per chain
`define N_COMPARES 4

// One chain per bridge
`define N_CHAINS 2

`endif

// File: common/dab_pkg.sv
// Shared types and address helper for the DAB modulator register write stream
`include "dab_cfg.svh"

package dab_pkg;

    // Generator control word
    typedef struct packed {
        logic [`DATA_WIDTH-3:0] reserved;
        logic                   load;
        logic                   run;
    } pwm_control_t;

    // A write word is a count for chain registers and a control word at CTRL_ADDR
    typedef union packed {
        logic [`DATA_WIDTH-1:0] count;
        pwm_control_t           control;
    } pwm_word_t;

    // Address of a register inside the window of a chain
    function automatic logic [`DATA_WIDTH-1:0] chain_register_address(
        input int unsigned chain,
        input int unsigned offset
    );
        logic [31:0] full_address;
        full_address = (chain + 1) * `CHAIN_STRIDE + offset;
        return full_address[`DATA_WIDTH-1:0];
    endfunction

endpackage

// File: pwm/pwm_chain.sv
// PWM chain producing a phase-shifted local count and the two leg signals of one bridge
`timescale 1ns/1ns
`include "dab_cfg.svh"

module pwm_chain (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   run,
    input  logic [`DATA_WIDTH-1:0] timebase,
    input  logic [`DATA_WIDTH-1:0] period,
    input  logic [`DATA_WIDTH-1:0] phase,
    input  logic [`DATA_WIDTH-1:0] compare_0,
    input  logic [`DATA_WIDTH-1:0] compare_1,
    input  logic [`DATA_WIDTH-1:0] compare_2,
    input  logic [`DATA_WIDTH-1:0] compare_3,
    output logic                   leg_a,
    output logic                   leg_b
);

    logic [`DATA_WIDTH:0]   count_sum;
    logic [`DATA_WIDTH-1:0] local_count;

    // Timebase and phase are both below the period, so one subtraction wraps the sum
    assign count_sum = {1'b0, timebase} + {1'b0, phase};

    always_ff @(posedge clock) begin
        if (!reset) begin
            local_count <= '0;
        end else if (count_sum >= {1'b0, period}) begin
            local_count <= count_sum[`DATA_WIDTH-1:0] - period;
        end else begin
            local_count <= count_sum[`DATA_WIDTH-1:0];
        end
    end

    // Leg a spans compares 0 to 2, leg b spans compares 1 to 3
    assign leg_a = run && (local_count >= compare_0) && (local_count < compare_2);
    assign leg_b = run && (local_count >= compare_1) && (local_count < compare_3);

endmodule

// File: pwm/pwm_generator.sv
// PWM generator with register decoder, shadow and active banks, shared timebase and bridge chains
`timescale 1ns/1ns
`include "dab_cfg.svh"

module pwm_generator (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_valid,
    input  logic [`DATA_WIDTH-1:0] write_address,
    input  dab_pkg::pwm_word_t     write_data,
    output logic                   write_ready,
    output logic [2*`N_CHAINS-1:0] pwm_out
);

    import dab_pkg::*;

    pwm_control_t           control_word;
    logic                   accept;
    logic                   control_hit;
    logic                   run;
    logic                   load_pending;
    logic                   load_now;
    logic                   timebase_wrap;
    logic [`DATA_WIDTH-1:0] timebase;

    logic [`DATA_WIDTH-1:0] shadow_period [`N_CHAINS];
    logic [`DATA_WIDTH-1:0] shadow_phase [`N_CHAINS];
    logic [`DATA_WIDTH-1:0] shadow_compare [`N_CHAINS][`N_COMPARES];
    logic [`DATA_WIDTH-1:0] active_period [`N_CHAINS];
    logic [`DATA_WIDTH-1:0] active_phase [`N_CHAINS];
    logic [`DATA_WIDTH-1:0] active_compare [`N_CHAINS][`N_COMPARES];

    // Writes stall while a bank load waits for the timebase wrap
    assign write_ready = !load_pending;
    assign accept = write_valid && write_ready;
    assign control_word = write_data.control;
    assign control_hit = accept && (write_address == `CTRL_ADDR);

    // An empty active period wraps at once, so the first load is taken without delay
    assign timebase_wrap = ({1'b0, timebase} + 1'b1) >= {1'b0, active_period[0]};
    assign load_now = load_pending && (!run || timebase_wrap);

    ////////////////////////////////////////////////////////////////////////////
    // Shadow bank

    always_ff @(posedge clock) begin
        if (accept) begin
            for (int n = 0; n < `N_CHAINS; n++) begin
                if (write_address == chain_register_address(n, `PERIOD_OFFSET)) begin
                    shadow_period[n] <= write_data.count;
                end
                if (write_address == chain_register_address(n, `PHASE_OFFSET)) begin
                    shadow_phase[n] <= write_data.count;
                end
                for (int k = 0; k < `N_COMPARES; k++) begin
                    if (write_address == chain_register_address(n,
                            `COMPARE_OFFSET + k * `COMPARE_STEP)) begin
                        shadow_compare[n][k] <= write_data.count;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Run control, timebase and active bank

    always_ff @(posedge clock) begin
        if (!reset) begin
            run <= 1'b0;
            load_pending <= 1'b0;
            timebase <= '0;
            for (int n = 0; n < `N_CHAINS; n++) begin
                active_period[n] <= '0;
                active_phase[n] <= '0;
                for (int k = 0; k < `N_COMPARES; k++) begin
                    active_compare[n][k] <= '0;
                end
            end
        end else begin
            if (!run || timebase_wrap) begin
                timebase <= '0;
            end else begin
                timebase <= timebase + 1'b1;
            end
            if (load_now) begin
                load_pending <= 1'b0;
                active_period <= shadow_period;
                active_phase <= shadow_phase;
                active_compare <= shadow_compare;
            end
            if (control_hit) begin
                run <= control_word.run;
                load_pending <= control_word.load;
            end
        end
    end

    for (genvar n = 0; n < `N_CHAINS; n++) begin : chain_gen
        pwm_chain chain_inst (
            .clock     (clock),
            .reset     (reset),
            .run       (run),
            .timebase  (timebase),
            .period    (active_period[n]),
            .phase     (active_phase[n]),
            .compare_0 (active_compare[n][0]),
            .compare_1 (active_compare[n][1]),
            .compare_2 (active_compare[n][2]),
            .compare_3 (active_compare[n][3]),
            .leg_a     (pwm_out[2*n]),
            .leg_b     (pwm_out[2*n+1])
        );
    end

endmodule

// File: dab_core/dab_operating_core.sv
// DAB operating core that derives compare values and bridge phase and programs the PWM generator
`timescale 1ns/1ns
`include "dab_cfg.svh"

module dab_operating_core (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          stop,
    input  logic                          update,
    input  logic [1:0]                    modulation_type,
    input  logic [`DATA_WIDTH-1:0]        period,
    input  logic signed [`DATA_WIDTH-1:0] phase_shift_1,
    input  logic signed [`DATA_WIDTH-1:0] phase_shift_2,
    input  logic                          write_ready,
    output logic                          write_valid,
    output logic [`DATA_WIDTH-1:0]        write_address,
    output dab_pkg::pwm_word_t            write_data,
    output logic                          modulator_status,
    output logic                          busy
);

    import dab_pkg::*;

    localparam logic signed [`DATA_WIDTH+1:0] wide_one = 1;
    localparam logic signed [`DATA_WIDTH+1:0] wide_two = 2;

    typedef enum logic [2:0] {
        state_idle,
        state_period,
        state_phase,
        state_compare,
        state_control,
        state_stop
    } core_state_t;

    core_state_t state;
    logic        chain;
    logic [1:0]  index;
    logic        stop_pending;
    logic        accept;
    logic        sequence_begin;

    logic [`DATA_WIDTH-1:0] period_reg;
    logic [`DATA_WIDTH-1:0] phase_reg;
    logic [`DATA_WIDTH-1:0] compare_reg [`N_COMPARES];

    // Two extra bits keep sums and negations of half-range values exact
    logic signed [`DATA_WIDTH+1:0] quarter;
    logic signed [`DATA_WIDTH+1:0] half;
    logic signed [`DATA_WIDTH+1:0] full;
    logic signed [`DATA_WIDTH+1:0] shift_limit;
    logic signed [`DATA_WIDTH+1:0] half_shift_2;
    logic signed [`DATA_WIDTH+1:0] inner_shift;
    logic signed [`DATA_WIDTH+1:0] saturated_shift_1;
    logic signed [`DATA_WIDTH+1:0] phase_sum;
    logic signed [`DATA_WIDTH+1:0] phase_wrapped;
    logic signed [`DATA_WIDTH+1:0] compare_calc [`N_COMPARES];

    ////////////////////////////////////////////////////////////////////////////
    // Modulation arithmetic

    assign quarter = $signed({4'b0000, period[`DATA_WIDTH-1:2]});
    assign half = $signed({3'b000, period[`DATA_WIDTH-1:1]});
    assign full = $signed({2'b00, period});
    assign shift_limit = quarter - wide_one;
    assign half_shift_2 = $signed({{2{phase_shift_2[`DATA_WIDTH-1]}}, phase_shift_2}) / wide_two;

    // Only extended phase shift moves the inner legs
    always_comb begin
        if (modulation_type != 2'd1) begin
            inner_shift = '0;
        end else if (half_shift_2 > shift_limit) begin
            inner_shift = shift_limit;
        end else if (half_shift_2 < -shift_limit) begin
            inner_shift = -shift_limit;
        end else begin
            inner_shift = half_shift_2;
        end
    end

    always_comb begin
        saturated_shift_1 = $signed({{2{phase_shift_1[`DATA_WIDTH-1]}}, phase_shift_1});
        if (saturated_shift_1 > half) begin
            saturated_shift_1 = half;
        end else if (saturated_shift_1 < -half) begin
            saturated_shift_1 = -half;
        end
        phase_sum = half + saturated_shift_1;
        if (phase_sum >= full) begin
            phase_wrapped = phase_sum - full;
        end else begin
            phase_wrapped = phase_sum;
        end
    end

    assign compare_calc[0] = quarter - inner_shift;
    assign compare_calc[1] = quarter + inner_shift;
    assign compare_calc[2] = half + quarter - inner_shift;
    assign compare_calc[3] = half + quarter + inner_shift;

    ////////////////////////////////////////////////////////////////////////////
    // Write sequencer

    assign accept = write_valid && write_ready;
    assign sequence_begin = (state == state_idle) && !stop_pending
                            && (start || (update && modulator_status));

    // Values are frozen for the whole sequence
    always_ff @(posedge clock) begin
        if (sequence_begin) begin
            period_reg <= period;
            phase_reg <= phase_wrapped[`DATA_WIDTH-1:0];
            for (int k = 0; k < `N_COMPARES; k++) begin
                compare_reg[k] <= compare_calc[k][`DATA_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            chain <= 1'b0;
            index <= 2'd0;
            stop_pending <= 1'b0;
            modulator_status <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (stop_pending) begin
                        stop_pending <= 1'b0;
                        state <= state_stop;
                    end else if (sequence_begin) begin
                        state <= state_period;
                    end
                end
                state_period: begin
                    if (accept) begin
                        chain <= ~chain;
                        if (chain) begin
                            state <= state_phase;
                        end
                    end
                end
                state_phase: begin
                    if (accept) begin
                        chain <= ~chain;
                        if (chain) begin
                            state <= state_compare;
                        end
                    end
                end
                state_compare: begin
                    if (accept) begin
                        index <= index + 2'd1;
                        if (index == 2'd3) begin
                            chain <= ~chain;
                            if (chain) begin
                                state <= state_control;
                            end
                        end
                    end
                end
                state_control: begin
                    if (accept) begin
                        modulator_status <= 1'b1;
                        state <= state_idle;
                    end
                end
                state_stop: begin
                    if (accept) begin
                        modulator_status <= 1'b0;
                        state <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
            if (stop) begin
                stop_pending <= 1'b1;
            end
        end
    end

    assign write_valid = (state != state_idle);
    assign busy = (state != state_idle);

    always_comb begin
        write_address = `CTRL_ADDR;
        write_data = '0;
        case (state)
            state_period: begin
                write_address = chain_register_address(int'(chain), `PERIOD_OFFSET);
                write_data.count = period_reg;
            end
            state_phase: begin
                write_address = chain_register_address(int'(chain), `PHASE_OFFSET);
                // First bridge is the phase reference
                write_data.count = chain ? phase_reg : '0;
            end
            state_compare: begin
                write_address = chain_register_address(int'(chain),
                                    `COMPARE_OFFSET + int'(index) * `COMPARE_STEP);
                write_data.count = compare_reg[index];
            end
            state_control: begin
                write_data.control.run = 1'b1;
                write_data.control.load = 1'b1;
            end
            default: begin
                write_data = '0;
            end
        endcase
    end

endmodule

// File: hdl/dab_modulator_top.sv
// DAB modulator top level where the operating core programs the two-bridge PWM generator
`timescale 1ns/1ns
`include "dab_cfg.svh"

module dab_modulator_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          stop,
    input  logic                          update,
    input  logic [1:0]                    modulation_type,
    input  logic [`DATA_WIDTH-1:0]        period,
    input  logic signed [`DATA_WIDTH-1:0] phase_shift_1,
    input  logic signed [`DATA_WIDTH-1:0] phase_shift_2,
    output logic                          modulator_status,
    output logic                          busy,
    output logic [2*`N_CHAINS-1:0]        pwm_out
);

    import dab_pkg::*;

    // Register write stream from the core to the generator
    logic                   write_valid;
    logic                   write_ready;
    logic [`DATA_WIDTH-1:0] write_address;
    pwm_word_t              write_data;

    dab_operating_core operating_core (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .modulation_type  (modulation_type),
        .period           (period),
        .phase_shift_1    (phase_shift_1),
        .phase_shift_2    (phase_shift_2),
        .write_ready      (write_ready),
        .write_valid      (write_valid),
        .write_address    (write_address),
        .write_data       (write_data),
        .modulator_status (modulator_status),
        .busy             (busy)
    );

    pwm_generator generator (
        .clock         (clock),
        .reset         (reset),
        .write_valid   (write_valid),
        .write_address (write_address),
        .write_data    (write_data),
        .write_ready   (write_ready),
        .pwm_out       (pwm_out)
    );

endmodule

// File: test/dab_modulator_checker.sv
// Bound assertions on the modulator register write stream, status and gate outputs
`timescale 1ns/1ns
`include "dab_cfg.svh"

module dab_modulator_checker (
    input logic                   clock,
    input logic                   reset,
    input logic                   write_valid,
    input logic                   write_ready,
    input logic [`DATA_WIDTH-1:0] write_address,
    input dab_pkg::pwm_word_t     write_data,
    input logic                   modulator_status,
    input logic                   busy,
    input logic [2*`N_CHAINS-1:0] pwm_out
);

    // A stalled write keeps its address and data until the generator takes it
    assert property (@(posedge clock) disable iff (!reset)
        write_valid && !write_ready |=> write_valid && $stable(write_address)
                                        && $stable(write_data))
    else $error("write stream changed while stalled");

    assert property (@(posedge clock) disable iff (!reset)
        !modulator_status && !$past(modulator_status) |-> pwm_out == '0)
    else $error("gate outputs active while the modulator is stopped");

    assert property (@(posedge clock) !reset |=> !busy && !write_valid)
    else $error("busy or write valid high right after reset");

endmodule

bind dab_modulator_top dab_modulator_checker write_stream_checker (
    .clock            (clock),
    .reset            (reset),
    .write_valid      (write_valid),
    .write_ready      (write_ready),
    .write_address    (write_address),
    .write_data       (write_data),
    .modulator_status (modulator_status),
    .busy             (busy),
    .pwm_out          (pwm_out)
);

// File: test/dab_modulator_tb.sv
// Testbench for the DAB modulator that measures gate widths and phase offsets against a model
`timescale 1ns/1ns
`include "dab_cfg.svh"

module dab_modulator_tb;

    localparam int timeout_cycles = 2000;

    logic                          clock;
    logic                          reset;
    logic                          start;
    logic                          stop;
    logic                          update;
    logic [1:0]                    modulation_type;
    logic [`DATA_WIDTH-1:0]        period;
    logic signed [`DATA_WIDTH-1:0] phase_shift_1;
    logic signed [`DATA_WIDTH-1:0] phase_shift_2;
    logic                          modulator_status;
    logic                          busy;
    logic [2*`N_CHAINS-1:0]        pwm_out;

    logic [31:0]            lfsr_state;
    logic [2*`N_CHAINS-1:0] samples [0:511];
    int                     running_period;
    int                     error_count;

    dab_modulator_top DUT (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .modulation_type  (modulation_type),
        .period           (period),
        .phase_shift_1    (phase_shift_1),
        .phase_shift_2    (phase_shift_2),
        .modulator_status (modulator_status),
        .busy             (busy),
        .pwm_out          (pwm_out)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers, reporting and compares

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int random_bits(input int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = value * 2 + int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic int random_range(input int low, input int high);
        return low + random_bits(12) % (high - low + 1);
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] to_count(input int value);
        return value[`DATA_WIDTH-1:0];
    endfunction

    task automatic stop_on_failure(input string line);
        error_count++;
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_count(input string what, input logic [`DATA_WIDTH-1:0] actual,
                                 input logic [`DATA_WIDTH-1:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error at %0t ns: %s is %0d, expected %0d",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic compare_status(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                      $time, what, actual, expected));
        end
    endtask

    task automatic compare_legs(input string what, input logic [2*`N_CHAINS-1:0] actual,
                                input logic [2*`N_CHAINS-1:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("** Error at %0t ns: %s is %b, expected %b",
                                      $time, what, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Model of the modulation rules

    function automatic int model_inner_shift(input int p, input int type_sel, input int shift_2);
        int limit;
        int s;
        limit = p / 4 - 1;
        s = shift_2 / 2;
        if (type_sel != 1) begin
            s = 0;
        end else if (s > limit) begin
            s = limit;
        end else if (s < -limit) begin
            s = -limit;
        end
        return s;
    endfunction

    function automatic int model_phase(input int p, input int shift_1);
        int saturated;
        saturated = shift_1;
        if (saturated > p / 2) begin
            saturated = p / 2;
        end else if (saturated < -(p / 2)) begin
            saturated = -(p / 2);
        end
        return (p / 2 + saturated) % p;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Waits and measurement

    task automatic wait_for_busy(input logic level);
        int cycles;
        cycles = 0;
        while (busy !== level) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure($sformatf("Timed out waiting for busy to become %b", level));
            end
        end
    endtask

    task automatic wait_for_status_low();
        int cycles;
        cycles = 0;
        while (modulator_status !== 1'b0) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_on_failure("Timed out waiting for the modulator to stop");
            end
        end
    endtask

    function automatic int first_rise(input int bit_index, input int p);
        for (int i = 1; i <= p; i++) begin
            if (samples[i][bit_index] && !samples[i-1][bit_index]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int high_count(input int bit_index, input int p);
        int count;
        count = 0;
        for (int i = 1; i <= p; i++) begin
            if (samples[i][bit_index]) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic check_waveform(input int p, input int phase, input int s);
        int rise [2*`N_CHAINS];
        int inner_delay;
        inner_delay = ((2 * s) % p + p) % p;
        for (int i = 0; i <= p; i++) begin
            @(negedge clock);
            samples[i] = pwm_out;
        end
        for (int b = 0; b < 2 * `N_CHAINS; b++) begin
            rise[b] = first_rise(b, p);
            if (rise[b] < 0) begin
                stop_on_failure($sformatf("Gate output %0d never rose within a period", b));
            end
            compare_count($sformatf("high time of gate %0d", b), to_count(high_count(b, p)),
                          to_count(p / 2));
        end
        compare_count("bridge 2 lead", to_count((rise[0] - rise[2] + p) % p), to_count(phase));
        compare_count("bridge 1 leg b delay", to_count((rise[1] - rise[0] + p) % p),
                      to_count(inner_delay));
        compare_count("bridge 2 leg b delay", to_count((rise[3] - rise[2] + p) % p),
                      to_count(inner_delay));
    endtask

    task automatic request_sequence(input logic use_update, input int p, input int type_sel,
                                    input int shift_1, input int shift_2);
        @(negedge clock);
        period = to_count(p);
        modulation_type = type_sel[1:0];
        phase_shift_1 = $signed(to_count(shift_1));
        phase_shift_2 = $signed(to_count(shift_2));
        start = !use_update;
        update = use_update;
        @(negedge clock);
        start = 1'b0;
        update = 1'b0;
        compare_status("busy after request", busy, 1'b1);
        wait_for_busy(1'b0);
    endtask

    task automatic run_and_check(input logic use_update, input int p, input int type_sel,
                                 input int shift_1, input int shift_2);
        int settle;
        request_sequence(use_update, p, type_sel, shift_1, shift_2);
        // A pending load waits out the old period before the new one starts
        settle = running_period + 2 * p + 4;
        for (int i = 0; i < settle; i++) begin
            @(negedge clock);
        end
        running_period = p;
        compare_status("modulator_status", modulator_status, 1'b1);
        check_waveform(p, model_phase(p, shift_1), model_inner_shift(p, type_sel, shift_2));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int p;
        lfsr_state = 32'h8336;
        running_period = 0;
        error_count = 0;
        reset = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        modulation_type = 2'd0;
        period = 16'd16;
        phase_shift_1 = '0;
        phase_shift_2 = '0;
        for (int i = 0; i < 3; i++) begin
            @(negedge clock);
        end
        reset = 1'b1;
        @(negedge clock);
        compare_legs("pwm_out after reset", pwm_out, '0);
        compare_status("modulator_status after reset", modulator_status, 1'b0);
        compare_status("busy after reset", busy, 1'b0);

        // Single phase shift
        for (int t = 0; t < 3; t++) begin
            p = 4 * random_range(4, 64);
            run_and_check(1'b0, p, 0, random_range(-p / 2, p / 2), random_range(-p, p));
        end

        // Extended phase shift, partly beyond the clamp range
        for (int t = 0; t < 4; t++) begin
            p = 4 * random_range(4, 64);
            run_and_check(1'b0, p, 1, random_range(-p / 2, p / 2), random_range(-p, p));
        end
        p = 4 * random_range(4, 64);
        run_and_check(1'b0, p, 1, 0, p);
        run_and_check(1'b0, p, 1, 0, -p);

        // Bridge shift beyond half a period and exactly at both limits
        p = 4 * random_range(4, 64);
        run_and_check(1'b0, p, 0, p / 2 + random_range(1, p), 0);
        run_and_check(1'b0, p, 0, -(p / 2) - random_range(1, p), 0);
        run_and_check(1'b0, p, 0, p / 2, 0);
        run_and_check(1'b0, p, 0, -(p / 2), 0);

        // The update follows a start whose load still waits for a wrap, so its writes stall
        p = 4 * random_range(4, 64);
        request_sequence(1'b0, p, 0, random_range(-p / 2, p / 2), 0);
        running_period = p;
        p = 4 * random_range(4, 64);
        run_and_check(1'b1, p, 1, random_range(-p / 2, p / 2), random_range(-p, p));
        @(negedge clock);
        stop = 1'b1;
        @(negedge clock);
        stop = 1'b0;
        wait_for_status_low();
        @(negedge clock);
        @(negedge clock);
        compare_legs("pwm_out after stop", pwm_out, '0);
        compare_status("busy after stop", busy, 1'b0);

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+common
common/dab_pkg.sv
pwm/pwm_chain.sv
pwm/pwm_generator.sv
dab_core/dab_operating_core.sv
hdl/dab_modulator_top.sv
test/dab_modulator_checker.sv
test/dab_modulator_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --timescale 1ns/1ns \
		--top-module dab_modulator_tb -f src.f --Mdir obj_dir

run: compile
	./obj_dir/Vdab_modulator_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation ended without passing"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
